// File: flist.f
design/ecc_slot_pkg.sv
design/ecc_au_pkg.sv
design/dbl_step_rom.sv
design/dbl_sequencer.sv
design/auc_dbl_top.sv
testbench/tb_clk_gen.sv
testbench/auc_dbl_props.sv
testbench/tb_auc_dbl.sv

// File: testbench/tb_auc_dbl.sv
`default_nettype none

module tb_auc_dbl;

    import ecc_slot_pkg::*;
    import ecc_au_pkg::*;

    localparam int          WIDTH        = 32;
    localparam logic [63:0] P            = 64'd4294967291;
    localparam int          RUNS         = 20;
    localparam int          DONE_LIMIT   = DBL_STEPS * 10;     // Worst step is 9 cycles
    localparam int          WATCHDOG_CYC = RUNS * DBL_STEPS * 8 + 2000;

    typedef struct packed {
        logic [WIDTH-1:0] x;
        logic [WIDTH-1:0] y;
        logic [WIDTH-1:0] z;
    } point_t;

    logic             clk;
    logic             rst;
    logic             en;
    logic [WIDTH-1:0] au_dat;
    logic             au_vld;
    au_req_t          au_req;
    logic             au_start;
    logic             wen;
    slot_t            wadd;
    logic [WIDTH-1:0] wdat;
    logic             done;

    logic [WIDTH-1:0] mem [8];          // Scratch memory model
    logic             poke_vld;         // Stray answer request
    logic             pending;
    logic [2:0]       lat_cnt;
    logic [WIDTH-1:0] answer;
    int               starts;
    int               writes;
    int               dones;
    int               errors;
    int               i;
    int unsigned      seed_val;
    string            cur_test;
    step_t            exp_line;
    point_t           pt;

    tb_clk_gen #(.PERIOD(10)) u_clk_gen (.clk(clk));

    auc_dbl_top #(.WIDTH(WIDTH)) u_auc_dbl_top (
        .clk(clk), .rst(rst), .en(en), .au_dat(au_dat), .au_vld(au_vld),
        .au_req(au_req), .au_start(au_start), .wen(wen), .wadd(wadd),
        .wdat(wdat), .done(done)
    );

    // ==============================
    // Field arithmetic mod p
    // ==============================

    function automatic logic [WIDTH-1:0] mod_mul(input logic [WIDTH-1:0] a, b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        return WIDTH'(prod % P);
    endfunction

    function automatic logic [WIDTH-1:0] mod_sub(input logic [WIDTH-1:0] a, b);
        return WIDTH'(({32'd0, a} + P - {32'd0, b}) % P);
    endfunction

    // Doubling with a = -3, straight from the formulas
    function automatic point_t dbl_ref(input point_t p1);
        logic [WIDTH-1:0] m, s, t, y2, z2;
        point_t r;
        y2  = mod_mul(p1.y, p1.y);
        z2  = mod_mul(p1.z, p1.z);
        m   = mod_mul(3, mod_sub(mod_mul(p1.x, p1.x), mod_mul(z2, z2)));
        s   = mod_mul(4, mod_mul(p1.x, y2));
        t   = mod_mul(y2, y2);
        r.x = mod_sub(mod_mul(m, m), mod_mul(2, s));
        r.y = mod_sub(mod_mul(m, mod_sub(s, r.x)), mod_mul(8, t));
        r.z = mod_mul(2, mod_mul(p1.y, p1.z));
        return r;
    endfunction

    // Expected program line k
    function automatic step_t prog_ref(input int k);
        case (k)
            0:       return '{'{op_mul,       slot_x,  slot_x,  4'd0}, slot_t3};
            1:       return '{'{op_mul_const, slot_t3, slot_t3, 4'd3}, slot_t3};
            2:       return '{'{op_mul,       slot_z,  slot_z,  4'd0}, slot_t4};
            3:       return '{'{op_mul,       slot_t4, slot_t4, 4'd0}, slot_t4};
            4:       return '{'{op_mul_const, slot_t4, slot_t4, 4'd3}, slot_t4};
            5:       return '{'{op_sub,       slot_t3, slot_t4, 4'd0}, slot_t3};
            6:       return '{'{op_mul,       slot_y,  slot_y,  4'd0}, slot_t4};
            7:       return '{'{op_mul,       slot_x,  slot_t4, 4'd0}, slot_t5};
            8:       return '{'{op_mul,       slot_t4, slot_t4, 4'd0}, slot_t4};
            9:       return '{'{op_mul_const, slot_t5, slot_t5, 4'd4}, slot_t5};
            10:      return '{'{op_mul,       slot_t3, slot_t3, 4'd0}, slot_t6};
            11:      return '{'{op_mul_const, slot_t5, slot_t5, 4'd2}, slot_t7};
            12:      return '{'{op_sub,       slot_t6, slot_t7, 4'd0}, slot_x};
            13:      return '{'{op_mul,       slot_y,  slot_z,  4'd0}, slot_z};
            14:      return '{'{op_mul_const, slot_z,  slot_z,  4'd2}, slot_z};
            15:      return '{'{op_mul_const, slot_t4, slot_t4, 4'd8}, slot_t4};
            16:      return '{'{op_sub,       slot_t5, slot_x,  4'd0}, slot_t5};
            17:      return '{'{op_mul,       slot_t3, slot_t5, 4'd0}, slot_t5};
            default: return '{'{op_sub,       slot_t5, slot_t4, 4'd0}, slot_y};
        endcase
    endfunction

    function automatic logic [WIDTH-1:0] au_result(input au_req_t req);
        case (req.op)
            op_mul:       return mod_mul(mem[req.src_a], mem[req.src_b]);
            op_mul_const: return mod_mul(mem[req.src_a], WIDTH'(req.konst));
            op_sub:       return mod_sub(mem[req.src_a], mem[req.src_b]);
            default:      return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [WIDTH-1:0] exp_v, act_v);
        $display("Fail %s %s: expected %0d actual %0d", cur_test, what, exp_v, act_v);
        errors++;
    endtask

    // ==============================
    // Memory and arithmetic unit models
    // ==============================

    always @(posedge clk)
    begin
        if (wen)
            mem[wadd] <= wdat;
    end

    always @(posedge clk)
    begin
        au_vld <= 1'b0;
        if (rst || en)
            pending <= 1'b0;                // Unit drops its work on a restart
        else if (pending)
        begin
            if (lat_cnt == 0)
            begin
                au_vld  <= 1'b1;
                au_dat  <= answer;
                pending <= 1'b0;
            end
            else
                lat_cnt <= lat_cnt - 1'b1;
        end
        else if (au_start)
        begin
            answer  <= au_result(au_req);   // Operands read at the request
            lat_cnt <= 3'($urandom % 6);    // 1 to 6 cycles
            pending <= 1'b1;
        end
        else if (poke_vld)
        begin
            au_vld <= 1'b1;
            au_dat <= $urandom;
        end
    end

    // ==============================
    // Request and write checker
    // ==============================

    always @(posedge clk)
    begin
        if (rst || en)
        begin
            starts <= 0;
            writes <= 0;
            dones  <= 0;
        end
        else
        begin
            if (au_start)
            begin
                exp_line = prog_ref(starts);
                if (starts >= DBL_STEPS)
                begin
                    $display("Error %s: more than %0d requests in one run", cur_test, DBL_STEPS);
                    errors++;
                end
                else
                begin
                    if (au_req.op !== exp_line.req.op)
                        report_mismatch($sformatf("step %0d op", starts), exp_line.req.op, au_req.op);
                    if (au_req.src_a !== exp_line.req.src_a)
                        report_mismatch($sformatf("step %0d src_a", starts),
                                        exp_line.req.src_a, au_req.src_a);
                    if (exp_line.req.op != op_mul_const && au_req.src_b !== exp_line.req.src_b)
                        report_mismatch($sformatf("step %0d src_b", starts),
                                        exp_line.req.src_b, au_req.src_b);
                    if (exp_line.req.op == op_mul_const && au_req.konst !== exp_line.req.konst)
                        report_mismatch($sformatf("step %0d konst", starts),
                                        exp_line.req.konst, au_req.konst);
                end
                starts <= starts + 1;
            end
            if (wen)
            begin
                exp_line = prog_ref(writes);
                if (wadd !== exp_line.dst)
                    report_mismatch($sformatf("write %0d slot", writes), exp_line.dst, wadd);
                if (done !== (writes == DBL_STEPS - 1))
                    report_mismatch($sformatf("write %0d done", writes),
                                    writes == DBL_STEPS - 1, done);
                writes <= writes + 1;
            end
            if (done)
                dones <= dones + 1;
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    task automatic quiet_after_reset();
        int n;
        cur_test = "quiet";
        for (n = 0; n < 50; n++)
        begin
            @(posedge clk);
            poke_vld <= (n % 7 == 3);
            if (au_start || wen || done)
            begin
                $display("Error quiet: DUT active without en in cycle %0d", n);
                errors++;
            end
        end
        @(posedge clk);
        poke_vld <= 1'b0;
    endtask

    // One run; cut > 0 restarts the program after that many writes
    task automatic double_point(input string name, input point_t p1, input int cut);
        point_t exp_pt;
        point_t got;
        int     n;
        cur_test = name;
        @(posedge clk);
        mem[slot_x] <= p1.x;
        mem[slot_y] <= p1.y;
        mem[slot_z] <= p1.z;
        en          <= 1'b1;
        @(posedge clk);
        en <= 1'b0;
        if (cut > 0)
        begin
            n = 0;
            while (n < cut)
            begin
                @(posedge clk);
                if (wen)
                    n++;
            end
            do
                @(posedge clk);
            while (!au_start);
            en <= 1'b1;                     // Lands while the request is outstanding
            @(posedge clk);
            en   <= 1'b0;
            p1.x = mem[slot_x];
            p1.y = mem[slot_y];
            p1.z = mem[slot_z];
        end
        exp_pt = dbl_ref(p1);
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!done && n < DONE_LIMIT);
        if (!done)
        begin
            $display("Error %s: no done within %0d cycles", name, DONE_LIMIT);
            errors++;
        end
        @(posedge clk);
        got = {mem[slot_x], mem[slot_y], mem[slot_z]};
        if (got.x !== exp_pt.x)
            report_mismatch("X3", exp_pt.x, got.x);
        if (got.y !== exp_pt.y)
            report_mismatch("Y3", exp_pt.y, got.y);
        if (got.z !== exp_pt.z)
            report_mismatch("Z3", exp_pt.z, got.z);
        if (starts != DBL_STEPS)
            report_mismatch("request count", DBL_STEPS, starts);
        if (writes != DBL_STEPS)
            report_mismatch("write count", DBL_STEPS, writes);
        if (dones != 1)
            report_mismatch("done count", 1, dones);
    endtask

    initial
    begin
        errors   = 0;
        cur_test = "reset";
        rst      = 1'b1;
        en       = 1'b0;
        au_vld   = 1'b0;
        au_dat   = '0;
        poke_vld = 1'b0;
        pending  = 1'b0;
        lat_cnt  = '0;
        answer   = '0;
        seed_val = $urandom(32'h28be);
        for (i = 0; i < 8; i++)
            mem[i] = 32'(i) * 32'h0101_0101 + 32'h0000_1234;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        quiet_after_reset();
        for (i = 0; i < RUNS; i++)
        begin
            pt.x = WIDTH'($urandom % P);
            pt.y = WIDTH'($urandom % P);
            pt.z = WIDTH'($urandom % P);
            if (i < 16)
                double_point($sformatf("point_%0d", i), pt, 0);
            else
                double_point($sformatf("restart_%0d", i - 16), pt, 1 + $urandom % 15);
        end
        errors += u_auc_dbl_top.u_seq.u_props.fail_cnt;
        $display("Summary: %0d runs, %0d errors", RUNS, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYC);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/auc_dbl_props.sv
`default_nettype none

module auc_dbl_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic au_start,
    input wire logic wen,
    input wire logic done
);

    int unsigned fail_cnt = 0;      // Read by the testbench at the end

    // ==============================
    // Request and write spacing
    // ==============================

    // A request is always followed by at least the wait and the write
    a_start_gap: assert property (@(posedge clk) disable iff (rst) au_start |=> !au_start)
    else
    begin
        fail_cnt++;
        $error("au_start high in two consecutive cycles");
    end

    a_wen_start: assert property (@(posedge clk) disable iff (rst) !(wen && au_start))
    else
    begin
        fail_cnt++;
        $error("wen and au_start high in the same cycle");
    end

    a_done_wen: assert property (@(posedge clk) disable iff (rst) done |-> wen)
    else
    begin
        fail_cnt++;
        $error("done high without wen");
    end

endmodule

bind dbl_sequencer auc_dbl_props u_props (
    .clk      (clk),
    .rst      (rst),
    .au_start (au_start),
    .wen      (wen),
    .done     (done)
);

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: design/auc_dbl_top.sv
`default_nettype none

module auc_dbl_top #(
    parameter int WIDTH = 256
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             en,

    // Arithmetic unit
    input  wire logic [WIDTH-1:0] au_dat,
    input  wire logic             au_vld,
    output ecc_au_pkg::au_req_t   au_req,
    output logic                  au_start,

    // Scratch memory write port
    output logic                  wen,
    output ecc_slot_pkg::slot_t   wadd,
    output logic [WIDTH-1:0]      wdat,

    output logic                  done
);

    import ecc_slot_pkg::*;
    import ecc_au_pkg::*;

    step_idx_t step_idx;
    step_t     step;

    // ==============================
    // Sequencer and program
    // ==============================

    dbl_sequencer #(
        .WIDTH    (WIDTH)
    ) u_seq (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .step     (step),
        .step_idx (step_idx),
        .au_dat   (au_dat),
        .au_vld   (au_vld),
        .au_req   (au_req),
        .au_start (au_start),
        .wen      (wen),
        .wadd     (wadd),
        .wdat     (wdat),
        .done     (done)
    );

    dbl_step_rom u_rom (
        .step_idx (step_idx),
        .step     (step)
    );

endmodule

`default_nettype wire

// File: design/dbl_sequencer.sv
`default_nettype none

module dbl_sequencer #(
    parameter int WIDTH = 256
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    en,

    // Step table
    input  wire ecc_au_pkg::step_t       step,
    output ecc_slot_pkg::step_idx_t      step_idx,

    // Arithmetic unit
    input  wire logic [WIDTH-1:0]        au_dat,
    input  wire logic                    au_vld,
    output ecc_au_pkg::au_req_t          au_req,
    output logic                         au_start,

    // Scratch memory write port
    output logic                         wen,
    output ecc_slot_pkg::slot_t          wadd,
    output logic [WIDTH-1:0]             wdat,

    output logic                         done
);

    import ecc_slot_pkg::*;

    typedef enum logic [1:0] {
        idle,
        issue,
        wait_au,
        write_back
    } seq_state_e;

    localparam step_idx_t LAST_STEP = step_idx_t'(DBL_STEPS - 1);

    seq_state_e       state;
    seq_state_e       state_nxt;
    logic             last_step;

    logic [WIDTH-1:0] res_q;    // Result held for the write cycle
    slot_t            dst_q;

    assign last_step = (step_idx == LAST_STEP);

    // ==============================
    // Run FSM
    // ==============================

    always_comb
    begin
        state_nxt = state;
        if (en)
        begin
            state_nxt = issue;  // Start, or drop the current run
        end
        else
        begin
            case (state)
                idle:
                begin
                    state_nxt = idle;
                end
                issue:
                begin
                    state_nxt = wait_au;
                end
                wait_au:
                begin
                    if (au_vld)
                        state_nxt = write_back;
                end
                write_back:
                begin
                    if (last_step)
                        state_nxt = idle;
                    else
                        state_nxt = issue;
                end
                default:
                begin
                    state_nxt = idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= idle;
        else
            state <= state_nxt;
    end

    // Step counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            step_idx <= '0;
        end
        else if (en)
        begin
            step_idx <= '0;
        end
        else if (state == write_back && !last_step)
        begin
            step_idx <= step_idx + 1'b1;
        end
    end

    // ==============================
    // Result capture
    // ==============================

    // au_vld outside wait_au has no request behind it
    always_ff @(posedge clk)
    begin
        if (state == wait_au && au_vld)
        begin
            res_q <= au_dat;
            dst_q <= step.dst;
        end
    end

    // ==============================
    // Outputs
    // ==============================

    assign au_req   = step.req;             // Step table is combinational
    assign au_start = (state == issue);

    assign wen      = (state == write_back);
    assign wadd     = dst_q;
    assign wdat     = res_q;

    assign done     = wen && last_step;     // With the Y3 write

endmodule

`default_nettype wire

// File: design/dbl_step_rom.sv
`default_nettype none

module dbl_step_rom (
    input  wire ecc_slot_pkg::step_idx_t step_idx,
    output ecc_au_pkg::step_t            step
);

    import ecc_slot_pkg::*;
    import ecc_au_pkg::*;

    // Packs one program line
    function automatic step_t prog_line(
        input au_op_e             op,
        input slot_t              src_a,
        input slot_t              src_b,
        input logic [KONST_W-1:0] konst,
        input slot_t              dst
    );
        step_t line;
        line.req.op    = op;
        line.req.src_a = src_a;
        line.req.src_b = src_b;
        line.req.konst = konst;
        line.dst       = dst;
        return line;
    endfunction

    // ==============================
    // Doubling program, a = -3
    // ==============================

    always_comb
    begin
        case (step_idx)
            // M = 3(X1^2 - Z1^4)
            5'd0:
                step = prog_line(op_mul, slot_x, slot_x, 4'd0, slot_t3);        // X1^2
            5'd1:
                step = prog_line(op_mul_const, slot_t3, slot_t3, 4'd3, slot_t3);
            5'd2:
                step = prog_line(op_mul, slot_z, slot_z, 4'd0, slot_t4);        // Z1^2
            5'd3:
                step = prog_line(op_mul, slot_t4, slot_t4, 4'd0, slot_t4);      // Z1^4
            5'd4:
                step = prog_line(op_mul_const, slot_t4, slot_t4, 4'd3, slot_t4);
            5'd5:
                step = prog_line(op_sub, slot_t3, slot_t4, 4'd0, slot_t3);      // M
            // S and T
            5'd6:
                step = prog_line(op_mul, slot_y, slot_y, 4'd0, slot_t4);        // Y1^2
            5'd7:
                step = prog_line(op_mul, slot_x, slot_t4, 4'd0, slot_t5);
            5'd8:
                step = prog_line(op_mul, slot_t4, slot_t4, 4'd0, slot_t4);      // T
            5'd9:
                step = prog_line(op_mul_const, slot_t5, slot_t5, 4'd4, slot_t5); // S
            // X3 = M^2 - 2S
            5'd10:
                step = prog_line(op_mul, slot_t3, slot_t3, 4'd0, slot_t6);
            5'd11:
                step = prog_line(op_mul_const, slot_t5, slot_t5, 4'd2, slot_t7);
            5'd12:
                step = prog_line(op_sub, slot_t6, slot_t7, 4'd0, slot_x);       // X3
            // Z3 = 2 Y1 Z1, needs Y1 before it is overwritten
            5'd13:
                step = prog_line(op_mul, slot_y, slot_z, 4'd0, slot_z);
            5'd14:
                step = prog_line(op_mul_const, slot_z, slot_z, 4'd2, slot_z);   // Z3
            // Y3 = M(S - X3) - 8T
            5'd15:
                step = prog_line(op_mul_const, slot_t4, slot_t4, 4'd8, slot_t4);
            5'd16:
                step = prog_line(op_sub, slot_t5, slot_x, 4'd0, slot_t5);
            5'd17:
                step = prog_line(op_mul, slot_t3, slot_t5, 4'd0, slot_t5);
            5'd18:
                step = prog_line(op_sub, slot_t5, slot_t4, 4'd0, slot_y);       // Y3
            default:
                step = prog_line(op_mul, slot_x, slot_x, 4'd0, slot_t3);
        endcase
    end

endmodule

`default_nettype wire

// File: design/ecc_au_pkg.sv
`default_nettype none

package ecc_au_pkg;

    import ecc_slot_pkg::*;

    // ==============================
    // Arithmetic unit requests
    // ==============================

    localparam int KONST_W = 4;

    typedef enum logic [1:0] {
        op_mul       = 2'd0,    // a * b mod p
        op_mul_const = 2'd1,    // a * konst mod p
        op_sub       = 2'd2     // a - b mod p
    } au_op_e;

    // Unit fetches both operands itself
    typedef struct packed {
        au_op_e             op;
        slot_t              src_a;
        slot_t              src_b;
        logic [KONST_W-1:0] konst;  // Multiplier for op_mul_const
    } au_req_t;

    // ==============================
    // Step table line
    // ==============================

    // Request plus the slot its result lands in
    typedef struct packed {
        au_req_t req;
        slot_t   dst;
    } step_t;

endpackage

`default_nettype wire

// File: design/ecc_slot_pkg.sv
`default_nettype none

package ecc_slot_pkg;

    // ==============================
    // Scratch memory slots
    // ==============================

    localparam int SLOT_W = 3;

    // X, Y and Z are read at the start of a run and overwritten with X3, Y3, Z3
    typedef enum logic [SLOT_W-1:0] {
        slot_x  = 3'd0,     // X1 in, X3 out
        slot_y  = 3'd1,     // Y1 in, Y3 out
        slot_z  = 3'd2,     // Z1 in, Z3 out
        slot_t3 = 3'd3,
        slot_t4 = 3'd4,
        slot_t5 = 3'd5,
        slot_t6 = 3'd6,
        slot_t7 = 3'd7
    } slot_t;

    // ==============================
    // Program sequencing
    // ==============================

    localparam int DBL_STEPS = 19;

    typedef logic [$clog2(DBL_STEPS)-1:0] step_idx_t;   // 5 bits

endpackage

`default_nettype wire
